// ==== hdl/mesh_defs.svh ====
`ifndef MESH_DEFS_SVH
`define MESH_DEFS_SVH

// 4x4 mesh, one router per node
`define MESH_NX 4
`define MESH_NY 4

`define MESH_XW $clog2(`MESH_NX)    // column address bits
`define MESH_YW $clog2(`MESH_NY)    // row address bits

// local, east, north, west, south
`define MESH_PORTS 5

`endif

// ==== hdl/mesh_pkg.sv ====
`default_nettype none

`include "mesh_defs.svh"

package mesh_pkg;

    // router address in the mesh
    typedef struct packed {
        logic [`MESH_XW-1:0] x;
        logic [`MESH_YW-1:0] y;
    } coord_t;

    // north is decreasing y, south is increasing y
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,
        port_west  = 3'd3,
        port_south = 3'd4
    } port_e;

    typedef logic [`MESH_PORTS-1:0] port_mask_t;    // indexed by port_e

    // destination relative to current router
    typedef struct packed {
        logic x_plus;
        logic x_min;
        logic y_plus;
        logic y_min;
        logic same_x;
        logic same_y;
    } dir_flags_t;

endpackage

`default_nettype wire

// ==== hdl/route_pkg.sv ====
`default_nettype none

package route_pkg;

    import mesh_pkg::*;

    typedef enum logic [1:0] {
        algo_xy         = 2'd0,    // deterministic
        algo_west_first = 2'd1,    // partially adaptive
        algo_odd_even   = 2'd2     // adaptive, column parity rules
    } algo_e;

    typedef struct packed {
        algo_e  algo;
        coord_t cur;
        coord_t dst;
    } route_req_t;

    // permitted output ports
    typedef struct packed {
        port_mask_t mask;
    } route_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/req_ack_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

// one-entry buffer between two four-phase req/ack links
module req_ack_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     up_req,
    output logic     up_ack,
    input  payload_t up_data,
    output logic     dn_req,
    input  logic     dn_ack,
    output payload_t dn_data
);

    logic     up_phase;    // upstream ack level
    logic     full;
    logic     dn_req_q;
    logic     dn_sent;     // dn_req already raised for this entry
    payload_t payload_q;
    logic     capture;

    // accept only once the previous upstream cycle has closed
    assign capture = !full && up_req && !up_phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_phase <= 1'b0;
        end else if (capture) begin
            up_phase <= 1'b1;
        end else if (up_phase && !up_req) begin
            up_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full     <= 1'b0;
            dn_req_q <= 1'b0;
            dn_sent  <= 1'b0;
        end else if (!full) begin
            full <= capture;
        end else if (!dn_sent) begin
            dn_req_q <= 1'b1;    // one clock after capture
            dn_sent  <= 1'b1;
        end else if (dn_req_q && dn_ack) begin
            dn_req_q <= 1'b0;
        end else if (!dn_req_q && !dn_ack) begin
            // downstream cycle done
            full    <= 1'b0;
            dn_sent <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            payload_q <= up_data;
        end
    end

    assign up_ack  = up_phase;
    assign dn_req  = dn_req_q;
    assign dn_data = payload_q;

    // payload held for the whole downstream request
    a_dn_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dn_req |=> (!dn_req || $stable(dn_data)));

    // ack answers a request seen on the previous clock
    a_up_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(up_ack) |-> $past(up_req));

endmodule

`default_nettype wire

// ==== hdl/turn_route.sv ====
`timescale 1ns/1ps
`default_nettype none

// XY and west-first port masks
module turn_route
    import mesh_pkg::*;
(
    input  dir_flags_t flags,
    output port_mask_t xy_mask,
    output port_mask_t wf_mask
);

    // x first, then y
    always_comb begin
        xy_mask = '0;
        if (flags.x_plus) begin
            xy_mask[port_east] = 1'b1;
        end else if (flags.x_min) begin
            xy_mask[port_west] = 1'b1;
        end else if (flags.y_plus) begin
            xy_mask[port_south] = 1'b1;
        end else if (flags.y_min) begin
            xy_mask[port_north] = 1'b1;
        end else begin
            xy_mask[port_local] = 1'b1;
        end
    end

    // no turns into west, so any west hop goes first
    always_comb begin
        wf_mask = '0;
        if (flags.same_x && flags.same_y) begin
            wf_mask[port_local] = 1'b1;
        end else if (flags.x_min) begin
            wf_mask[port_west] = 1'b1;
        end else if (flags.x_plus) begin
            wf_mask[port_east]  = 1'b1;
            wf_mask[port_north] = flags.y_min;    // adaptive vertical choice
            wf_mask[port_south] = flags.y_plus;
        end else if (flags.same_x) begin
            wf_mask[port_north] = flags.y_min;
            wf_mask[port_south] = flags.y_plus;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/odd_even_route.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defs.svh"

// odd-even turn model
module odd_even_route
    import mesh_pkg::*;
#(
    parameter bit located_in_ni = 1'b0    // 1 lifts the parity rule on east-bound vertical hops
) (
    input  coord_t     cur,
    input  coord_t     dst,
    output port_mask_t mask
);

    logic signed [`MESH_XW:0] xdiff;
    logic signed [`MESH_YW:0] ydiff;
    port_e                    vert_port;

    // one extra bit so the difference keeps its sign
    assign xdiff = $signed({1'b0, dst.x}) - $signed({1'b0, cur.x});
    assign ydiff = $signed({1'b0, dst.y}) - $signed({1'b0, cur.y});

    assign vert_port = (ydiff < 0) ? port_north : port_south;

    always_comb begin
        mask = '0;
        if (xdiff == 0 && ydiff == 0) begin
            mask[port_local] = 1'b1;
        end else if (xdiff == 0) begin    // same column
            mask[vert_port] = 1'b1;
        end else if (ydiff == 0) begin    // same row
            if (xdiff < 0) begin
                mask[port_west] = 1'b1;
            end else begin
                mask[port_east] = 1'b1;
            end
        end else if (xdiff > 0) begin
            // east-bound, vertical only from odd columns
            if (cur.x[0] || located_in_ni) begin
                mask[vert_port] = 1'b1;
            end
            // odd target column or two or more columns to go
            if (dst.x[0] || xdiff != 1) begin
                mask[port_east] = 1'b1;
            end
        end else begin
            mask[port_west] = 1'b1;
            if (!cur.x[0]) begin    // even column
                mask[vert_port] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/route_compute.sv ====
`timescale 1ns/1ps
`default_nettype none

// combinational route computation, algorithm chosen per request
module route_compute
    import mesh_pkg::*;
    import route_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  route_req_t req,
    output route_rsp_t rsp
);

    dir_flags_t flags;
    port_mask_t xy_mask;
    port_mask_t wf_mask;
    port_mask_t oe_mask;

    // comparator
    assign flags.x_plus = req.dst.x > req.cur.x;
    assign flags.x_min  = req.dst.x < req.cur.x;
    assign flags.y_plus = req.dst.y > req.cur.y;
    assign flags.y_min  = req.dst.y < req.cur.y;
    assign flags.same_x = req.dst.x == req.cur.x;
    assign flags.same_y = req.dst.y == req.cur.y;

    turn_route u_turn (
        .flags   (flags),
        .xy_mask (xy_mask),
        .wf_mask (wf_mask)
    );

    odd_even_route #(
        .located_in_ni (1'b0)
    ) u_odd_even (
        .cur  (req.cur),
        .dst  (req.dst),
        .mask (oe_mask)
    );

    always_comb begin
        case (req.algo)
            algo_west_first: rsp.mask = wf_mask;
            algo_odd_even:   rsp.mask = oe_mask;
            default:         rsp.mask = xy_mask;    // xy and the spare code
        endcase
    end

    // every algorithm offers at least one port
    a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(req) |-> rsp.mask != '0);

    a_local_alone: assert property (@(posedge clk) disable iff (!rst_n)
        (!$isunknown(req) && rsp.mask[port_local]) |-> $onehot(rsp.mask));

    a_xy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (!$isunknown(req) && req.algo == algo_xy) |-> $onehot(rsp.mask));

endmodule

`default_nettype wire

// ==== hdl/mesh_route_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// registered route stage, up to two routes in flight
module mesh_route_top
    import route_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_req,
    output logic       req_ack,
    input  route_req_t req_data,
    output logic       rsp_req,
    input  logic       rsp_ack,
    output route_rsp_t rsp_data
);

    logic       mid_req;
    logic       mid_ack;
    route_req_t mid_data;
    route_rsp_t comp_rsp;    // computed from in_slot contents

    req_ack_slot #(
        .payload_t (route_req_t)
    ) in_slot (
        .clk     (clk),
        .rst_n   (rst_n),
        .up_req  (req_req),
        .up_ack  (req_ack),
        .up_data (req_data),
        .dn_req  (mid_req),
        .dn_ack  (mid_ack),
        .dn_data (mid_data)
    );

    route_compute u_compute (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mid_data),
        .rsp   (comp_rsp)
    );

    req_ack_slot #(
        .payload_t (route_rsp_t)
    ) out_slot (
        .clk     (clk),
        .rst_n   (rst_n),
        .up_req  (mid_req),
        .up_ack  (mid_ack),
        .up_data (comp_rsp),
        .dn_req  (rsp_req),
        .dn_ack  (rsp_ack),
        .dn_data (rsp_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_mesh_route.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defs.svh"

// file-driven testbench for the route stage with random back-pressure on the response link
module tb_mesh_route
    import mesh_pkg::*;
    import route_pkg::*;
();

    localparam int MAX_CASES  = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int BP_CYCLES  = 30;

    logic       clk;
    logic       rst_n;
    logic       req_req;
    logic       req_ack;
    route_req_t req_data;
    logic       rsp_req;
    logic       rsp_ack;
    route_rsp_t rsp_data;

    route_req_t case_req [MAX_CASES];
    port_mask_t case_mask [MAX_CASES];
    int         n_cases;
    int         total;          // file cases plus the back-pressure trio
    port_mask_t exp_q [$];
    int         idx_q [$];
    int         rsp_count;
    int         active_idx;     // case now on the response link
    logic       hold;           // consumer keeps rsp_ack low
    integer     seed;
    logic       prev_req;
    port_mask_t prev_mask;
    logic       ack_seen;

    mesh_route_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_req  (req_req),
        .req_ack  (req_ack),
        .req_data (req_data),
        .rsp_req  (rsp_req),
        .rsp_ack  (rsp_ack),
        .rsp_data (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input int idx);
        if (got !== exp) begin
            $display("** Error at %0d ns: case %0d mask %b, expected %b", $time, idx, got, exp);
            abort_run("mask mismatch");
        end
    endtask

    task automatic check_idle(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run("handshake level mismatch");
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_req_ack(input logic lvl);
        int n;
        n = 0;
        while (req_ack !== lvl) begin
            if (n == WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for req_ack to go %b", lvl));
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_rsp_req(input logic lvl);
        int n;
        n = 0;
        while (rsp_req !== lvl || (lvl && hold)) begin
            if (n == WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for rsp_req to go %b", lvl));
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic load_cases();
        int         fd;
        int         cnt;
        int         a, cx, cy, dx, dy, m;
        string      line;
        route_req_t r;
        fd = $fopen("tests/route_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/route_cases.txt");
        end
        n_cases = 0;
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%d %d %d %d %d %b", a, cx, cy, dx, dy, m);
                if (cnt != 6 || n_cases == MAX_CASES) begin
                    abort_run($sformatf("bad case line: %s", line));
                end
                if (cx >= `MESH_NX || dx >= `MESH_NX || cy >= `MESH_NY || dy >= `MESH_NY) begin
                    abort_run($sformatf("coordinate outside the mesh: %s", line));
                end
                r.algo  = algo_e'(a[1:0]);
                r.cur.x = cx[`MESH_XW-1:0];
                r.cur.y = cy[`MESH_YW-1:0];
                r.dst.x = dx[`MESH_XW-1:0];
                r.dst.y = dy[`MESH_YW-1:0];
                case_req[n_cases]  = r;
                case_mask[n_cases] = m[`MESH_PORTS-1:0];
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases < 3) begin
            abort_run("fewer than three cases in tests/route_cases.txt");
        end
        total = n_cases + 3;
    endtask

    // one full four-phase cycle on the request link
    task automatic send_req(input int idx);
        req_data = case_req[idx];
        req_req  = 1'b1;
        exp_q.push_back(case_mask[idx]);
        idx_q.push_back(idx);
        wait_req_ack(1'b1);
        req_req = 1'b0;
        wait_req_ack(1'b0);
    endtask

    task automatic run_producer();
        int n;
        for (int i = 0; i < n_cases; i++) begin
            send_req(i);
        end
        n = 0;
        while (rsp_count != n_cases) begin
            if (n == WAIT_LIMIT) begin
                abort_run("timeout waiting for the case stream to drain");
            end
            next_cycle();
            n++;
        end
        hold <= 1'b1;
        send_req(0);
        send_req(1);
        // both slots full so the third request must not be acked
        req_data = case_req[2];
        req_req  = 1'b1;
        exp_q.push_back(case_mask[2]);
        idx_q.push_back(2);
        repeat (BP_CYCLES) begin
            next_cycle();
            check_idle(req_ack, 1'b0, "req_ack");
        end
        hold <= 1'b0;
        wait_req_ack(1'b1);
        req_req = 1'b0;
        wait_req_ack(1'b0);
    endtask

    task automatic take_responses();
        int         delay;
        port_mask_t exp;
        for (int k = 0; k < total; k++) begin
            wait_rsp_req(1'b1);
            if (exp_q.size() == 0) begin
                abort_run("response without a pending request");
            end
            exp        = exp_q.pop_front();
            active_idx = idx_q.pop_front();
            check_mask(rsp_data.mask, exp, active_idx);
            delay = {$random(seed)} % 6;
            repeat (delay) next_cycle();
            rsp_ack = 1'b1;
            wait_rsp_req(1'b0);
            rsp_ack = 1'b0;
            rsp_count <= rsp_count + 1;
        end
    endtask

    // response link protocol sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            prev_req <= 1'b0;
            ack_seen <= 1'b0;
        end else begin
            if (prev_req && rsp_req) begin
                check_mask(rsp_data.mask, prev_mask, active_idx);    // held while rsp_req high
            end
            if (prev_req && !rsp_req) begin
                check_idle(ack_seen, 1'b1, "rsp_ack before rsp_req fall");
            end
            ack_seen  <= rsp_req && (ack_seen || rsp_ack);
            prev_req  <= rsp_req;
            prev_mask <= rsp_data.mask;
        end
    end

    initial begin
        seed       = 44;
        rst_n      = 1'b0;
        req_req    = 1'b0;
        req_data   = '0;
        rsp_ack    = 1'b0;
        active_idx = 0;
        hold      <= 1'b0;
        rsp_count <= 0;
        load_cases();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        check_idle(req_ack, 1'b0, "req_ack");
        check_idle(rsp_req, 1'b0, "rsp_req");
        fork
            run_producer();
            take_responses();
        join
        next_cycle();
        if (exp_q.size() != 0 || rsp_count != total) begin
            abort_run("responses missing at end of run");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/route_cases.txt ====
# algo (0 xy, 1 west-first, 2 odd-even), cur_x, cur_y, dst_x, dst_y
# expected mask in binary, msb first: south west north east local
0 1 1 3 2 00010
0 2 1 0 3 01000
0 1 1 1 3 10000
0 2 3 2 0 00100
0 2 2 2 2 00001
1 3 1 0 3 01000
1 0 2 2 0 00110
1 1 0 3 3 10010
1 2 3 2 1 00100
1 0 0 0 2 10000
1 3 3 3 3 00001
2 1 1 3 3 10010
2 1 2 2 0 00100
2 0 3 2 1 00010
2 2 0 3 2 00010
2 3 0 1 2 01000
2 2 3 0 1 01100
2 2 1 2 3 10000
2 3 2 1 2 01000
2 1 3 1 3 00001

// ==== files.f ====
+incdir+hdl
hdl/mesh_pkg.sv
hdl/route_pkg.sv
hdl/req_ack_slot.sv
hdl/turn_route.sv
hdl/odd_even_route.sv
hdl/route_compute.sv
hdl/mesh_route_top.sv
tests/tb_mesh_route.sv

// ==== Makefile ====
TOP = tb_mesh_route

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
